// File: pco_pkg.sv
// counter width, counter constants and controller state encoding, imported by the pco, controller and top
package pco_pkg;

	// width of every pco/controller counter and configured limit
	localparam int unsigned cntr_bits = 13;

	typedef logic [cntr_bits-1:0] cntr_t;

	localparam cntr_t cntr_zero = '0;
	localparam cntr_t cntr_one  = cntr_t'(1); // pco counter restarts here, never at 0

	// duty-cycling controller states
	// idle_s       reset state, leaves as soon as the block is enabled
	// desync_s     reset tracker counts lead and slave resets
	// synclead_s   synced as the fastest node, duty window open
	// syncslave_s  synced to a faster node, duty window open
	// checklead_s  window closed, next reset decides lead sync or desync
	// checklave_s  window closed, next reset decides slave sync or desync
	typedef enum logic [2:0] {
		idle_s      = 3'd0,
		desync_s    = 3'd1,
		synclead_s  = 3'd2,
		syncslave_s = 3'd3,
		checklead_s = 3'd4,
		checklave_s = 3'd5
	} ctrl_state_t;

endpackage

// File: cfg_pkg.sv
// bit layout of the serial configuration register, shared by the register and the testbench
package cfg_pkg;
	import pco_pkg::*;

	localparam int unsigned seq_len       = 16; // encoded coupling sequence length
	localparam int unsigned seq_cntr_bits = $clog2(seq_len);
	localparam logic [seq_cntr_bits-1:0] seq_last = seq_cntr_bits'(seq_len - 1);

	localparam int unsigned ctrl_bits = 4; // pco_en, pulsegen_en, controller_en, pco_design_sel
	localparam int unsigned cfg_width = ctrl_bits + seq_len + 8 * cntr_bits;

	// field lsb positions, counted up from the lsb
	// n_duty sits at the bottom, control bits at the top
	localparam int unsigned n_duty_pos     = 0;
	localparam int unsigned n_pulse_pos    = n_duty_pos + cntr_bits;
	localparam int unsigned n_duty_l_pos   = n_pulse_pos + cntr_bits;
	localparam int unsigned n_duty_h_pos   = n_duty_l_pos + cntr_bits;
	localparam int unsigned n_pco_pos      = n_duty_h_pos + cntr_bits;
	localparam int unsigned n_cstr_pos     = n_pco_pos + cntr_bits;
	localparam int unsigned n_blackout_pos = n_cstr_pos + cntr_bits;
	localparam int unsigned n_delay_pos    = n_blackout_pos + cntr_bits;
	localparam int unsigned seq_pos        = n_delay_pos + cntr_bits;
	localparam int unsigned pco_en_pos         = seq_pos + seq_len;
	localparam int unsigned pulsegen_en_pos    = pco_en_pos + 1;
	localparam int unsigned controller_en_pos  = pco_en_pos + 2;
	localparam int unsigned pco_design_sel_pos = pco_en_pos + 3; // msb of the register

endpackage

// File: cfg_shift_reg.sv
// serial configuration register: shadow shift chain, load-strobed active copy and field decode
module cfg_shift_reg import pco_pkg::*, cfg_pkg::*; (
	input  logic clk,
	input  logic greset_n,
	input  logic spi_din,
	input  logic cfg_load,
	output logic spi_dout,
	output logic pco_en,
	output logic pulsegen_en,
	output logic controller_en,
	output logic pco_design_sel,
	output logic [0:seq_len-1] encoded, // bit 0 is played first
	output cntr_t n_delay,
	output cntr_t n_blackout,
	output cntr_t n_cstr,
	output cntr_t n_pco,
	output cntr_t n_duty_h,
	output cntr_t n_duty_l,
	output cntr_t n_pulse,
	output cntr_t n_duty
);

	logic [cfg_width-1:0] shadow_reg;
	logic [cfg_width-1:0] active_reg;

	// first bit in ends up at the msb after cfg_width clocks
	always_ff @(posedge clk) begin
		shadow_reg <= {shadow_reg[cfg_width-2:0], spi_din};
	end

	assign spi_dout = shadow_reg[cfg_width-1]; // daisy-chain out

	// active copy starts all zero so every block comes up disabled
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			active_reg <= '0;
		end else if (cfg_load) begin
			active_reg <= shadow_reg;
		end
	end

	assign pco_en         = active_reg[pco_en_pos];
	assign pulsegen_en    = active_reg[pulsegen_en_pos];
	assign controller_en  = active_reg[controller_en_pos];
	assign pco_design_sel = active_reg[pco_design_sel_pos];
	assign encoded        = active_reg[seq_pos +: seq_len]; // field msb maps to index 0

	// pco limits
	assign n_delay    = active_reg[n_delay_pos +: cntr_bits];
	assign n_blackout = active_reg[n_blackout_pos +: cntr_bits];
	assign n_cstr     = active_reg[n_cstr_pos +: cntr_bits];
	assign n_pco      = active_reg[n_pco_pos +: cntr_bits];
	// controller limits
	assign n_duty_h   = active_reg[n_duty_h_pos +: cntr_bits];
	assign n_duty_l   = active_reg[n_duty_l_pos +: cntr_bits];
	assign n_pulse    = active_reg[n_pulse_pos +: cntr_bits];
	assign n_duty     = active_reg[n_duty_pos +: cntr_bits];

endmodule

// File: pco_osc.sv
// progressively-slowing pulse-coupled oscillator with peak coupling, blackout and forced reset
module pco_osc import pco_pkg::*; (
	input  logic  clk,
	input  logic  greset_n,
	input  logic  enable,
	input  logic  peak_in,
	input  logic  pco_design_sel, // restart delay from 1 after a forced reset
	input  cntr_t n_delay,
	input  cntr_t n_blackout,
	input  cntr_t n_cstr,
	input  cntr_t n_pco,
	output cntr_t cntr_pco,
	output logic  pco_pulse_out,
	output logic  pco_pulse_type
);

	cntr_t cntr_del;
	cntr_t cntr_trig;
	logic [2:0] cpulse_sync; // two sync flops plus previous sample
	logic cpulse;
	logic cpulse_will_reset;
	logic trig_clk;
	logic trig_clk_will_reset;
	logic cntr_trig_en;
	logic cntr_pco_rst;

	// rising edge of synced peak, ignored during blackout
	assign cpulse = cpulse_sync[1] && !cpulse_sync[2] && (cntr_pco > n_blackout);
	// extra bit so cntr_pco + n_cstr cannot wrap
	assign cpulse_will_reset = ({1'b0, cntr_pco} + {1'b0, n_cstr}) >= {1'b0, n_pco};

	assign cntr_trig_en = (cntr_del == n_delay); // initial delay done
	assign trig_clk = ((cntr_trig + 1'b1) == cntr_pco) && cntr_trig_en;
	assign trig_clk_will_reset = (cntr_pco + 1'b1) == n_pco;

	assign cntr_pco_rst = enable && ((cpulse && cpulse_will_reset) || (trig_clk && trig_clk_will_reset));
	assign pco_pulse_out = cntr_pco_rst;
	assign pco_pulse_type = enable && cpulse && cpulse_will_reset; // 1 = forced by peak

	// peak_in comes from another domain
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			cpulse_sync <= '0;
		end else if (enable) begin
			cpulse_sync <= {cpulse_sync[1:0], peak_in};
		end
	end

	// delay counter, saturates at n_delay
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			cntr_del <= cntr_zero;
		end else if (cntr_pco_rst) begin
			cntr_del <= (pco_design_sel && pco_pulse_type) ? cntr_one : cntr_zero;
		end else if (enable && (cntr_del != n_delay)) begin
			cntr_del <= cntr_del + 1'b1;
		end
	end

	// trigger counter wraps at cntr_pco, so each step of cntr_pco takes longer
	always_ff @(posedge clk) begin
		if (!greset_n || cntr_pco_rst) begin
			cntr_trig <= cntr_zero;
		end else if (enable) begin
			if ((cntr_trig + 1'b1) == cntr_pco) begin
				cntr_trig <= cntr_zero;
			end else begin
				cntr_trig <= cntr_trig + 1'b1;
			end
		end
	end

	// pco phase counter
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			cntr_pco <= cntr_one;
		end else if (enable) begin
			if (cntr_pco_rst) begin
				cntr_pco <= cntr_one; // natural or forced reset
			end else if (cpulse) begin
				cntr_pco <= cntr_pco + n_cstr; // coupling jump, stays below n_pco
			end else if (trig_clk) begin
				cntr_pco <= cntr_pco + 1'b1;
			end
		end
	end

endmodule

// File: duty_ctrl.sv
// duty-cycling controller: tracks lead/slave sync from pco resets and opens the duty window
module duty_ctrl import pco_pkg::*; (
	input  logic        clk,
	input  logic        greset_n,
	input  logic        enable,
	input  logic        pco_pulse_out,
	input  logic        pco_pulse_type,
	input  cntr_t       cntr_pco,
	input  cntr_t       n_duty_h,
	input  cntr_t       n_duty_l,
	input  cntr_t       n_pulse,
	input  cntr_t       n_duty,
	output logic        duty_out,
	output ctrl_state_t state
);

	ctrl_state_t next_state;
	cntr_t cntr1_lead;  // consecutive natural resets
	cntr_t cntr1_slave; // late forced resets
	cntr_t cntr2;       // pco pulses seen while synced
	logic natural_reset;
	logic forced_reset;
	logic synchronized;
	logic duty_out_en;
	logic sync_lead;
	logic sync_slave;
	logic cntr1_rst;
	logic cntr2_rst;

	assign natural_reset = pco_pulse_out && !pco_pulse_type;
	assign forced_reset  = pco_pulse_out && pco_pulse_type;
	assign synchronized  = sync_lead || sync_slave;
	assign duty_out_en   = (cntr_pco >= n_duty_l) && (cntr_pco <= n_duty_h) && synchronized;

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			duty_out <= 1'b0;
		end else if (enable) begin
			duty_out <= duty_out_en;
		end
	end

	// reset tracker
	always_ff @(posedge clk) begin
		if (!greset_n || cntr1_rst) begin
			cntr1_lead  <= cntr_zero;
			cntr1_slave <= cntr_zero;
		end else if (enable) begin
			if (forced_reset) begin
				if (cntr_pco <= n_duty_h) begin // premature, likely a stray node
					cntr1_lead  <= cntr_zero;
					cntr1_slave <= cntr_zero;
				end else begin
					cntr1_slave <= cntr1_slave + 1'b1; // pulled in by a faster node
				end
			end else if (natural_reset) begin
				cntr1_lead <= cntr1_lead + 1'b1; // fastest or alone
			end
		end
	end

	// duty period counter, stops one past n_duty
	always_ff @(posedge clk) begin
		if (!greset_n || cntr2_rst) begin
			cntr2 <= cntr_zero;
		end else if (enable && pco_pulse_out && synchronized && (cntr2 <= n_duty)) begin
			cntr2 <= cntr2 + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			state <= idle_s;
		end else if (enable) begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		sync_lead  = 1'b0;
		sync_slave = 1'b0;
		cntr1_rst  = 1'b0;
		cntr2_rst  = 1'b0;
		case (state)
			idle_s: begin
				if (enable) begin
					next_state = desync_s;
					cntr1_rst  = 1'b1;
				end
			end
			desync_s: begin
				if (cntr1_lead == n_pulse) begin
					next_state = synclead_s;
					cntr2_rst  = 1'b1;
				end else if (cntr1_slave == n_pulse) begin
					next_state = syncslave_s;
					cntr2_rst  = 1'b1;
				end
			end
			synclead_s: begin
				sync_lead = 1'b1;
				if (cntr2 > n_duty) next_state = checklead_s; // window used up
			end
			syncslave_s: begin
				sync_slave = 1'b1;
				if (cntr2 > n_duty) next_state = checklave_s;
			end
			checklead_s: begin
				if (natural_reset) begin // still the leader
					next_state = synclead_s;
					cntr2_rst  = 1'b1;
				end else if (forced_reset) begin
					next_state = desync_s;
					cntr1_rst  = 1'b1;
				end
			end
			checklave_s: begin
				if (forced_reset) begin // still following
					next_state = syncslave_s;
					cntr2_rst  = 1'b1;
				end else if (natural_reset) begin
					next_state = desync_s;
					cntr1_rst  = 1'b1;
				end
			end
			default: next_state = idle_s;
		endcase
	end

endmodule

// File: seq_pulsegen.sv
// coupling sequence generator, plays the encoded bits once per trigger and holds the last bit
module seq_pulsegen import cfg_pkg::*; (
	input  logic clk,
	input  logic greset_n,
	input  logic enable,
	input  logic trigger, // pco reset pulse
	input  logic [0:seq_len-1] encoded,
	output logic pulsegen_out
);

	logic [seq_cntr_bits-1:0] seq_idx;

	assign pulsegen_out = encoded[seq_idx];

	// parked on the last bit until the next trigger
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			seq_idx <= seq_last;
		end else if (enable) begin
			if (trigger && (seq_idx == seq_last)) begin
				seq_idx <= '0; // re-arm only from the end
			end else if (seq_idx != seq_last) begin
				seq_idx <= seq_idx + 1'b1;
			end
		end
	end

endmodule

// File: sync_node_top.sv
// pco sync node top, joins the configuration register to the oscillator, controller and pulse generator
module sync_node_top import pco_pkg::*, cfg_pkg::*; (
	input  logic        clk,
	input  logic        greset_n,
	input  logic        spi_din,
	input  logic        cfg_load,
	input  logic        peak_in, // correlator peak, now from outside
	output logic        spi_dout,
	output cntr_t       cntr_pco,
	output logic        pco_pulse_out,
	output logic        pco_pulse_type,
	output logic        duty_out,
	output ctrl_state_t state,
	output logic        pulsegen_out
);

	logic pco_en;
	logic pulsegen_en;
	logic controller_en;
	logic pco_design_sel;
	logic [0:seq_len-1] encoded;
	cntr_t n_delay;
	cntr_t n_blackout;
	cntr_t n_cstr;
	cntr_t n_pco;
	cntr_t n_duty_h;
	cntr_t n_duty_l;
	cntr_t n_pulse;
	cntr_t n_duty;

	cfg_shift_reg cfg1 (
		.clk(clk), .greset_n(greset_n), .spi_din(spi_din), .cfg_load(cfg_load),
		.spi_dout(spi_dout), .pco_en(pco_en), .pulsegen_en(pulsegen_en),
		.controller_en(controller_en), .pco_design_sel(pco_design_sel), .encoded(encoded),
		.n_delay(n_delay), .n_blackout(n_blackout), .n_cstr(n_cstr), .n_pco(n_pco),
		.n_duty_h(n_duty_h), .n_duty_l(n_duty_l), .n_pulse(n_pulse), .n_duty(n_duty)
	);

	pco_osc pco1 (
		.clk(clk), .greset_n(greset_n), .enable(pco_en), .peak_in(peak_in),
		.pco_design_sel(pco_design_sel), .n_delay(n_delay), .n_blackout(n_blackout),
		.n_cstr(n_cstr), .n_pco(n_pco), .cntr_pco(cntr_pco),
		.pco_pulse_out(pco_pulse_out), .pco_pulse_type(pco_pulse_type)
	);

	duty_ctrl ctrl1 (
		.clk(clk), .greset_n(greset_n), .enable(controller_en),
		.pco_pulse_out(pco_pulse_out), .pco_pulse_type(pco_pulse_type), .cntr_pco(cntr_pco),
		.n_duty_h(n_duty_h), .n_duty_l(n_duty_l), .n_pulse(n_pulse), .n_duty(n_duty),
		.duty_out(duty_out), .state(state)
	);

	// each pco reset launches one coupling sequence
	seq_pulsegen pgen1 (
		.clk(clk), .greset_n(greset_n), .enable(pulsegen_en), .trigger(pco_pulse_out),
		.encoded(encoded), .pulsegen_out(pulsegen_out)
	);

endmodule

// File: tb_sync_node.sv
// testbench that loads the serial config into sync_node_top and checks its outputs with assertions
module tb_sync_node import pco_pkg::*, cfg_pkg::*; ();

	localparam int clk_period = 20;
	// limits written into the serial configuration
	localparam cntr_t lim_delay    = 13'd20;
	localparam cntr_t lim_blackout = 13'd5;
	localparam cntr_t lim_cstr     = 13'd6;
	localparam cntr_t lim_pco      = 13'd12;
	localparam cntr_t lim_duty_l   = 13'd2;
	localparam cntr_t lim_duty_h   = 13'd6;
	localparam cntr_t lim_pulse    = 13'd3;
	localparam cntr_t lim_duty     = 13'd2;
	localparam logic [seq_len-1:0] seq_code = 16'hB667; // msb played first
	// natural period is the delay plus 1+2+..+(n_pco-1) cycles and some slack
	localparam int period_cycles = lim_delay + (lim_pco * (lim_pco - 1)) / 2 + 2;
	localparam int watchdog_time = (cfg_width + 20 + 40 * period_cycles) * clk_period;

	logic clk;
	logic greset_n;
	logic spi_din;
	logic cfg_load;
	logic peak_in;
	logic spi_dout;
	cntr_t cntr_pco;
	logic pco_pulse_out;
	logic pco_pulse_type;
	logic duty_out;
	ctrl_state_t state;
	logic pulsegen_out;

	integer seed = 32'h20b907f8;
	int cyc = 0;                 // edges seen so far
	int nat_cnt = 0;             // natural resets since start
	int gap;
	int missed;
	logic cfg_loaded = 1'b0;
	logic [seq_cntr_bits-1:0] idx_model = '1;
	logic duty_cond;
	logic seq_exp;
	// cover flags
	logic reset_seen = 1'b0;
	logic serial_seen = 1'b0;
	logic forced_seen = 1'b0;
	logic lead_seen = 1'b0;
	logic duty_seen = 1'b0;
	logic seq_seen = 1'b0;

	sync_node_top uut (
		.clk(clk), .greset_n(greset_n), .spi_din(spi_din), .cfg_load(cfg_load),
		.peak_in(peak_in), .spi_dout(spi_dout), .cntr_pco(cntr_pco),
		.pco_pulse_out(pco_pulse_out), .pco_pulse_type(pco_pulse_type),
		.duty_out(duty_out), .state(state), .pulsegen_out(pulsegen_out)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// window open while synced, seen on duty_out one cycle later
	assign duty_cond = (cntr_pco >= lim_duty_l) && (cntr_pco <= lim_duty_h) &&
		(state == synclead_s || state == syncslave_s);
	assign seq_exp = cfg_loaded ? seq_code[seq_len - 1 - idx_model] : 1'b0;

	function automatic logic [cfg_width-1:0] build_config();
		logic [cfg_width-1:0] cfg;
		cfg = '0;
		cfg[pco_en_pos] = 1'b1;
		cfg[pulsegen_en_pos] = 1'b1;
		cfg[controller_en_pos] = 1'b1;
		cfg[pco_design_sel_pos] = 1'b1;
		cfg[seq_pos +: seq_len] = seq_code;
		cfg[n_delay_pos +: cntr_bits] = lim_delay;
		cfg[n_blackout_pos +: cntr_bits] = lim_blackout;
		cfg[n_cstr_pos +: cntr_bits] = lim_cstr;
		cfg[n_pco_pos +: cntr_bits] = lim_pco;
		cfg[n_duty_h_pos +: cntr_bits] = lim_duty_h;
		cfg[n_duty_l_pos +: cntr_bits] = lim_duty_l;
		cfg[n_pulse_pos +: cntr_bits] = lim_pulse;
		cfg[n_duty_pos +: cntr_bits] = lim_duty;
		return cfg;
	endfunction

	// allowed controller moves where the previous pulse decides the check states
	function automatic bit legal_move(logic [2:0] prev_s, logic [2:0] next_s,
			logic pulse, logic ptype);
		bit ok;
		case (prev_s)
			idle_s:      ok = next_s inside {idle_s, desync_s};
			desync_s:    ok = next_s inside {desync_s, synclead_s, syncslave_s};
			synclead_s:  ok = next_s inside {synclead_s, checklead_s};
			syncslave_s: ok = next_s inside {syncslave_s, checklave_s};
			checklead_s: ok = (pulse && !ptype) ? (next_s == synclead_s) :
				(pulse ? (next_s == desync_s) : (next_s == checklead_s));
			checklave_s: ok = (pulse && ptype) ? (next_s == syncslave_s) :
				(pulse ? (next_s == desync_s) : (next_s == checklave_s));
			default:     ok = 1'b0;
		endcase
		return ok;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Mismatch at time %0t: %s", $time, msg);
		$display("test failed");
		$fatal(1, "check failed");
	endtask

	// shifts msb first and then strobes cfg_load for one cycle
	task automatic load_config(input logic [cfg_width-1:0] cfg);
		for (int i = cfg_width - 1; i >= 0; i--) begin
			@(posedge clk);
			#2 spi_din = cfg[i];
		end
		@(posedge clk);
		#2 cfg_load = 1'b1;
		@(posedge clk);
		#2 cfg_load = 1'b0;
	endtask

	task automatic step_cycle(input logic peak);
		@(posedge clk);
		#2 peak_in = peak;
		spi_din = 1'($random(seed)); // keeps the serial path busy
	endtask

	// reference models and cover flags
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cfg_load) cfg_loaded <= 1'b1;
		if (pco_pulse_out && !pco_pulse_type) nat_cnt <= nat_cnt + 1;
		if (pco_pulse_out && pco_pulse_type) forced_seen <= 1'b1;
		if (cyc >= 1 && !greset_n) reset_seen <= 1'b1;
		if (cyc >= cfg_width && spi_dout) serial_seen <= 1'b1; // a one made it through
		if (state == synclead_s) lead_seen <= 1'b1;
		if (duty_out) duty_seen <= 1'b1;
		if (!greset_n) begin
			idx_model <= '1; // parked on the last bit
		end else if (cfg_loaded) begin
			if (pco_pulse_out && idx_model == seq_len - 1) begin
				idx_model <= '0;
				seq_seen <= 1'b1;
			end else if (idx_model != seq_len - 1) begin
				idx_model <= idx_model + 1'b1;
			end
		end
	end

	a_reset: assert property (@(posedge clk) !(cyc >= 1 && (!greset_n || !cfg_loaded)) ||
		(!duty_out && state == idle_s && !pco_pulse_out && cntr_pco == 13'd1))
		else report_mismatch("outputs not at reset values while disabled");
	a_serial: assert property (@(posedge clk)
		!(cyc >= cfg_width) || spi_dout == $past(spi_din, cfg_width))
		else report_mismatch("spi_dout is not spi_din delayed by the register length");
	a_natural: assert property (@(posedge clk) !(cyc >= 1 && pco_pulse_out && !pco_pulse_type) ||
		cntr_pco == lim_pco - 1)
		else report_mismatch("natural pulse away from n_pco minus 1");
	a_forced: assert property (@(posedge clk) !(cyc >= 1 && pco_pulse_out && pco_pulse_type) ||
		(cntr_pco > lim_blackout && int'(cntr_pco) + int'(lim_cstr) >= int'(lim_pco)))
		else report_mismatch("forced pulse inside blackout or too early");
	a_restart: assert property (@(posedge clk) !(cyc >= 2 && $past(pco_pulse_out)) ||
		cntr_pco == 13'd1)
		else report_mismatch("cntr_pco not 1 after a pulse");
	a_below: assert property (@(posedge clk) !(cyc >= 1) || cntr_pco < lim_pco)
		else report_mismatch("cntr_pco reached n_pco");
	a_first_lead: assert property (@(posedge clk)
		!(cyc >= 1 && state == synclead_s && !lead_seen) || nat_cnt == lim_pulse)
		else report_mismatch("lead sync not after n_pulse natural resets");
	a_duty: assert property (@(posedge clk) !(cyc >= 2) || duty_out == $past(duty_cond))
		else report_mismatch("duty_out differs from last cycle window condition");
	a_fsm: assert property (@(posedge clk) !(cyc >= 2) ||
		legal_move($past(state), state, $past(pco_pulse_out), $past(pco_pulse_type)))
		else report_mismatch("illegal controller state transition");
	a_seq: assert property (@(posedge clk) !(cyc >= 1) || pulsegen_out == seq_exp)
		else report_mismatch("pulsegen_out differs from sequence bit");

	initial begin
		#(watchdog_time);
		$display("timeout: the run did not finish within 40 pco periods");
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		greset_n = 1'b0;
		spi_din = 1'b0;
		cfg_load = 1'b0;
		peak_in = 1'b0;
		repeat (2) @(posedge clk);
		#2 greset_n = 1'b1;
		load_config(build_config());
		while (nat_cnt < 7) step_cycle(1'b0); // quiet until lead sync and one check round
		repeat (30) begin
			gap = 10 + ($unsigned($random(seed)) % 64);
			repeat (gap) step_cycle(1'b0);
			step_cycle(1'b1);
		end
		repeat (20) step_cycle(1'b0);
		missed = 0;
		if (!reset_seen) begin
			$display("behavior not reached: reset and disable values");
			missed++;
		end
		if (!serial_seen) begin
			$display("behavior not reached: serial path");
			missed++;
		end
		if (nat_cnt == 0 || !forced_seen) begin
			$display("behavior not reached: natural and forced pco pulses");
			missed++;
		end
		if (!lead_seen || !duty_seen) begin
			$display("behavior not reached: lead sync with duty window");
			missed++;
		end
		if (!seq_seen) begin
			$display("behavior not reached: sequence restart");
			missed++;
		end
		if (missed > 0) begin
			$display("test failed");
			$fatal(1, "coverage incomplete");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

// File: project.f
pco_pkg.sv
cfg_pkg.sv
cfg_shift_reg.sv
pco_osc.sv
duty_ctrl.sv
seq_pulsegen.sv
sync_node_top.sv
tb_sync_node.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" && verilator --binary --timing --assert -Wno-fatal --top-module tb_sync_node -f project.f && ./obj_dir/Vtb_sync_node || exit 1
